/* logic/scope_cfg_pkg.sv */
// shared constants and the register map of the scope configuration block
package scope_cfg_pkg;

  // channel count is fixed by the address map
  localparam int N_CH = 2;

  // system bus widths
  localparam int BUS_W  = 32;
  localparam int ADDR_W = 20;

  // settings register widths
  localparam int DEC_W     = 17;
  localparam int DLY_W     = 32;
  localparam int TRG_SRC_W = 4;

  // trigger source code for a software trigger
  localparam logic [TRG_SRC_W-1:0] TRG_SRC_SW = 4'd1;

  // threshold magnitude after reset, even channels positive and odd ones negative
  localparam int THRESH_RST = 5000;

  // hysteresis after reset
  localparam int HYST_RST = 20;

  // decimation after reset, no decimation
  localparam logic [DEC_W-1:0] DEC_RST = 17'd1;

  // register offsets within the scope window
  typedef enum logic [ADDR_W-1:0] {
    REG_CTRL     = 20'h00000,
    REG_TRIG     = 20'h00004,
    REG_THRESH_A = 20'h00008,
    REG_THRESH_B = 20'h0000C,
    REG_DLY_A    = 20'h00010,
    REG_DEC_A    = 20'h00014,
    REG_WP_A     = 20'h00018,
    REG_HYST_A   = 20'h00020,
    REG_HYST_B   = 20'h00024,
    REG_TRIG_CLR = 20'h00094,
    REG_DLY_B    = 20'h00110,
    REG_DEC_B    = 20'h00114,
    REG_WP_B     = 20'h00118
  } scope_reg_e;

  // bit positions in a channel's byte lane of REG_CTRL
  localparam int CTRL_ARM_BIT   = 0;
  localparam int CTRL_RST_BIT   = 1;
  localparam int CTRL_KEEP_BIT  = 3;
  localparam int CTRL_INDEP_BIT = 5;

endpackage

/* logic/scope_cmd_decode.sv */
`timescale 1ns/1ps

// per-channel command strobes, trigger source and sticky mode bits
module scope_cmd_decode (
  input  logic                                                      adc_clk_i,
  input  logic                                                      adc_rstn_i,
  input  logic [scope_cfg_pkg::BUS_W-1:0]                           sys_addr_i,
  input  logic [scope_cfg_pkg::BUS_W-1:0]                           sys_wdata_i,
  input  logic                                                      sys_wen_i,
  output logic [scope_cfg_pkg::N_CH-1:0]                            arm_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                            rst_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                            trig_sw_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                            we_keep_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                            trig_clr_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                            indep_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                            new_src_o,
  output logic [scope_cfg_pkg::N_CH*scope_cfg_pkg::TRG_SRC_W-1:0]   trg_src_o
);

  import scope_cfg_pkg::*;

  localparam int LANE_W = 8;

  logic wr_ctrl;
  logic wr_trig;
  logic wr_clr;

  assign wr_ctrl = sys_wen_i && (sys_addr_i[ADDR_W-1:0] == REG_CTRL);
  assign wr_trig = sys_wen_i && (sys_addr_i[ADDR_W-1:0] == REG_TRIG);
  assign wr_clr  = sys_wen_i && (sys_addr_i[ADDR_W-1:0] == REG_TRIG_CLR);

  for (genvar gv = 0; gv < N_CH; gv++) begin : g_ch
    logic [LANE_W-1:0]    lane;
    logic [TRG_SRC_W-1:0] src;

    // channel n owns byte lane n of the write data
    assign lane = sys_wdata_i[gv*LANE_W +: LANE_W];
    assign src  = lane[TRG_SRC_W-1:0];

    always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
        arm_o[gv]                            <= 1'b0;
        rst_o[gv]                            <= 1'b0;
        trig_sw_o[gv]                        <= 1'b0;
        trig_clr_o[gv]                       <= 1'b0;
        new_src_o[gv]                        <= 1'b0;
        we_keep_o[gv]                        <= 1'b0;
        indep_o[gv]                          <= 1'b0;
        trg_src_o[gv*TRG_SRC_W +: TRG_SRC_W] <= '0;
      end else begin
        arm_o[gv]      <= wr_ctrl && lane[CTRL_ARM_BIT];
        rst_o[gv]      <= wr_ctrl && lane[CTRL_RST_BIT];
        trig_sw_o[gv]  <= wr_trig && (src == TRG_SRC_SW);
        new_src_o[gv]  <= wr_trig && (src != '0);
        // bit 0 unlocks a disabled trigger
        trig_clr_o[gv] <= wr_clr && lane[0];
        // an all-zero lane byte leaves the sticky bits alone
        if (wr_ctrl && (lane != '0)) begin
          we_keep_o[gv] <= lane[CTRL_KEEP_BIT];
          indep_o[gv]   <= lane[CTRL_INDEP_BIT];
        end
        if (wr_trig && (src != '0)) begin
          trg_src_o[gv*TRG_SRC_W +: TRG_SRC_W] <= src;
        end
      end
    end

    // a strobe held over two cycles needs two writes in a row to its register
    a_ctrl_pulse : assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
      (arm_o[gv] || rst_o[gv]) && $past(arm_o[gv] || rst_o[gv])
      |-> $past(wr_ctrl, 1) && $past(wr_ctrl, 2));

    a_trig_pulse : assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
      (trig_sw_o[gv] || new_src_o[gv]) && $past(trig_sw_o[gv] || new_src_o[gv])
      |-> $past(wr_trig, 1) && $past(wr_trig, 2));

    a_clr_pulse : assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
      trig_clr_o[gv] && $past(trig_clr_o[gv])
      |-> $past(wr_clr, 1) && $past(wr_clr, 2));
  end

endmodule

/* logic/scope_set_regs.sv */
`timescale 1ns/1ps

// per-channel trigger and acquisition settings
module scope_set_regs #(
  parameter int DW = 14
) (
  input  logic                                              adc_clk_i,
  input  logic                                              adc_rstn_i,
  input  logic [scope_cfg_pkg::BUS_W-1:0]                   sys_addr_i,
  input  logic [scope_cfg_pkg::BUS_W-1:0]                   sys_wdata_i,
  input  logic                                              sys_wen_i,
  output logic [scope_cfg_pkg::N_CH*DW-1:0]                 set_tresh_o,
  output logic [scope_cfg_pkg::N_CH*DW-1:0]                 set_hyst_o,
  output logic [scope_cfg_pkg::N_CH*scope_cfg_pkg::DLY_W-1:0] set_dly_o,
  output logic [scope_cfg_pkg::N_CH*scope_cfg_pkg::DEC_W-1:0] set_dec_o
);

  import scope_cfg_pkg::*;

  logic [ADDR_W-1:0] addr;

  assign addr = sys_addr_i[ADDR_W-1:0];

  for (genvar gv = 0; gv < N_CH; gv++) begin : g_ch
    // register offsets of this channel
    localparam logic [ADDR_W-1:0] THR_ADR  = (gv == 0) ? REG_THRESH_A : REG_THRESH_B;
    localparam logic [ADDR_W-1:0] HYST_ADR = (gv == 0) ? REG_HYST_A   : REG_HYST_B;
    localparam logic [ADDR_W-1:0] DLY_ADR  = (gv == 0) ? REG_DLY_A    : REG_DLY_B;
    localparam logic [ADDR_W-1:0] DEC_ADR  = (gv == 0) ? REG_DEC_A    : REG_DEC_B;

    // thresholds start on opposite sides of zero
    localparam logic [DW-1:0] THR_INIT =
      (gv % 2 == 0) ? DW'(THRESH_RST) : DW'(-THRESH_RST);

    always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
        set_tresh_o[gv*DW +: DW]       <= THR_INIT;
        set_hyst_o[gv*DW +: DW]        <= DW'(HYST_RST);
        set_dly_o[gv*DLY_W +: DLY_W]   <= '0;
        set_dec_o[gv*DEC_W +: DEC_W]   <= DEC_RST;
      end else if (sys_wen_i) begin
        if (addr == THR_ADR) begin
          set_tresh_o[gv*DW +: DW] <= sys_wdata_i[DW-1:0];
        end
        if (addr == HYST_ADR) begin
          set_hyst_o[gv*DW +: DW] <= sys_wdata_i[DW-1:0];
        end
        if (addr == DLY_ADR) begin
          set_dly_o[gv*DLY_W +: DLY_W] <= sys_wdata_i[DLY_W-1:0];
        end
        if (addr == DEC_ADR) begin
          set_dec_o[gv*DEC_W +: DEC_W] <= sys_wdata_i[DEC_W-1:0];
        end
      end
    end
  end

endmodule

/* logic/scope_chan_mux.sv */
`timescale 1ns/1ps

// channel 1 follows channel 0 unless it runs in independent mode
module scope_chan_mux (
  input  logic                                                    adc_clk_i,
  input  logic [scope_cfg_pkg::N_CH-1:0]                          arm_i,
  input  logic [scope_cfg_pkg::N_CH-1:0]                          rst_i,
  input  logic [scope_cfg_pkg::N_CH-1:0]                          trig_sw_i,
  input  logic [scope_cfg_pkg::N_CH-1:0]                          we_keep_i,
  input  logic [scope_cfg_pkg::N_CH-1:0]                          trig_clr_i,
  input  logic [scope_cfg_pkg::N_CH-1:0]                          indep_i,
  input  logic [scope_cfg_pkg::N_CH-1:0]                          new_src_i,
  input  logic [scope_cfg_pkg::N_CH*scope_cfg_pkg::TRG_SRC_W-1:0] trg_src_i,
  input  logic [scope_cfg_pkg::N_CH*scope_cfg_pkg::DLY_W-1:0]     set_dly_i,
  input  logic [scope_cfg_pkg::N_CH*scope_cfg_pkg::DEC_W-1:0]     set_dec_i,
  output logic [scope_cfg_pkg::N_CH-1:0]                          adc_arm_do_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                          adc_rst_do_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                          adc_trig_sw_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                          adc_we_keep_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                          trig_dis_clr_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                          indep_mode_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                          new_trg_src_o,
  output logic [scope_cfg_pkg::N_CH*scope_cfg_pkg::TRG_SRC_W-1:0] trg_src_o,
  output logic [scope_cfg_pkg::N_CH*scope_cfg_pkg::DLY_W-1:0]     set_dly_o,
  output logic [scope_cfg_pkg::N_CH*scope_cfg_pkg::DEC_W-1:0]     set_dec_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                          set_dec1_o
);

  import scope_cfg_pkg::*;

  logic [N_CH-1:0] dec1;

  assign indep_mode_o = indep_i;

  assign dec1[0] = (set_dec_i[DEC_W-1:0] == DEC_W'(1));
  assign dec1[1] = (set_dec_i[2*DEC_W-1:DEC_W] == DEC_W'(1));

  // channel 0 always drives itself
  assign adc_arm_do_o[0]            = arm_i[0];
  assign adc_rst_do_o[0]            = rst_i[0];
  assign adc_trig_sw_o[0]           = trig_sw_i[0];
  assign adc_we_keep_o[0]           = we_keep_i[0];
  assign trig_dis_clr_o[0]          = trig_clr_i[0];
  assign new_trg_src_o[0]           = new_src_i[0];
  assign set_dec1_o[0]              = dec1[0];
  assign trg_src_o[TRG_SRC_W-1:0]   = trg_src_i[TRG_SRC_W-1:0];
  assign set_dly_o[DLY_W-1:0]       = set_dly_i[DLY_W-1:0];
  assign set_dec_o[DEC_W-1:0]       = set_dec_i[DEC_W-1:0];

  // channel 1 takes channel 0's controls unless it is independent
  assign adc_arm_do_o[1]   = indep_i[1] ? arm_i[1]      : arm_i[0];
  assign adc_rst_do_o[1]   = indep_i[1] ? rst_i[1]      : rst_i[0];
  assign adc_trig_sw_o[1]  = indep_i[1] ? trig_sw_i[1]  : trig_sw_i[0];
  assign adc_we_keep_o[1]  = indep_i[1] ? we_keep_i[1]  : we_keep_i[0];
  assign trig_dis_clr_o[1] = indep_i[1] ? trig_clr_i[1] : trig_clr_i[0];
  assign new_trg_src_o[1]  = indep_i[1] ? new_src_i[1]  : new_src_i[0];
  assign set_dec1_o[1]     = indep_i[1] ? dec1[1]       : dec1[0];
  assign trg_src_o[2*TRG_SRC_W-1:TRG_SRC_W] =
    indep_i[1] ? trg_src_i[2*TRG_SRC_W-1:TRG_SRC_W] : trg_src_i[TRG_SRC_W-1:0];
  assign set_dly_o[2*DLY_W-1:DLY_W] =
    indep_i[1] ? set_dly_i[2*DLY_W-1:DLY_W] : set_dly_i[DLY_W-1:0];
  assign set_dec_o[2*DEC_W-1:DEC_W] =
    indep_i[1] ? set_dec_i[2*DEC_W-1:DEC_W] : set_dec_i[DEC_W-1:0];

  // mirrored controls of channel 1 track channel 0 on every edge
  a_mirror : assert property (@(posedge adc_clk_i) !indep_i[1] |->
    (adc_arm_do_o[1] == adc_arm_do_o[0]) && (adc_rst_do_o[1] == adc_rst_do_o[0]) &&
    (adc_trig_sw_o[1] == adc_trig_sw_o[0]) && (adc_we_keep_o[1] == adc_we_keep_o[0]) &&
    (trig_dis_clr_o[1] == trig_dis_clr_o[0]) && (new_trg_src_o[1] == new_trg_src_o[0]) &&
    (set_dec1_o[1] == set_dec1_o[0]) &&
    (trg_src_o[2*TRG_SRC_W-1:TRG_SRC_W] == trg_src_o[TRG_SRC_W-1:0]) &&
    (set_dly_o[2*DLY_W-1:DLY_W] == set_dly_o[DLY_W-1:0]) &&
    (set_dec_o[2*DEC_W-1:DEC_W] == set_dec_o[DEC_W-1:0]));

endmodule

/* logic/scope_read_mux.sv */
`timescale 1ns/1ps

// registered readback of the settings and write pointers
module scope_read_mux #(
  parameter int DW  = 14,
  parameter int RSZ = 14
) (
  input  logic                                                adc_clk_i,
  input  logic                                                adc_rstn_i,
  input  logic [scope_cfg_pkg::BUS_W-1:0]                     sys_addr_i,
  input  logic                                                sys_wen_i,
  input  logic                                                sys_ren_i,
  input  logic [scope_cfg_pkg::N_CH*DW-1:0]                   set_tresh_i,
  input  logic [scope_cfg_pkg::N_CH*DW-1:0]                   set_hyst_i,
  input  logic [scope_cfg_pkg::N_CH*scope_cfg_pkg::DLY_W-1:0] set_dly_i,
  input  logic [scope_cfg_pkg::N_CH*scope_cfg_pkg::DEC_W-1:0] set_dec_i,
  input  logic [scope_cfg_pkg::N_CH*RSZ-1:0]                  adc_wp_cur_i,
  output logic [scope_cfg_pkg::BUS_W-1:0]                     sys_rdata_o,
  output logic                                                sys_ack_o
);

  import scope_cfg_pkg::*;

  scope_reg_e reg_sel;
  logic       sys_req;

  assign reg_sel = scope_reg_e'(sys_addr_i[ADDR_W-1:0]);
  assign sys_req = sys_wen_i || sys_ren_i;

  // every request is answered on the next cycle
  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      sys_ack_o <= 1'b0;
    end else begin
      sys_ack_o <= sys_req;
    end
  end

  // narrow registers come back zero-extended
  always_ff @(posedge adc_clk_i) begin
    case (reg_sel)
      REG_THRESH_A: sys_rdata_o <= BUS_W'(set_tresh_i[0*DW +: DW]);
      REG_THRESH_B: sys_rdata_o <= BUS_W'(set_tresh_i[1*DW +: DW]);
      REG_HYST_A:   sys_rdata_o <= BUS_W'(set_hyst_i[0*DW +: DW]);
      REG_HYST_B:   sys_rdata_o <= BUS_W'(set_hyst_i[1*DW +: DW]);
      REG_DLY_A:    sys_rdata_o <= BUS_W'(set_dly_i[0*DLY_W +: DLY_W]);
      REG_DLY_B:    sys_rdata_o <= BUS_W'(set_dly_i[1*DLY_W +: DLY_W]);
      REG_DEC_A:    sys_rdata_o <= BUS_W'(set_dec_i[0*DEC_W +: DEC_W]);
      REG_DEC_B:    sys_rdata_o <= BUS_W'(set_dec_i[1*DEC_W +: DEC_W]);
      REG_WP_A:     sys_rdata_o <= BUS_W'(adc_wp_cur_i[0*RSZ +: RSZ]);
      REG_WP_B:     sys_rdata_o <= BUS_W'(adc_wp_cur_i[1*RSZ +: RSZ]);
      // control, trigger and unmapped offsets
      default:      sys_rdata_o <= '0;
    endcase
  end

  a_ack_follows_req : assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
    sys_ack_o |-> $past(sys_req));

endmodule

/* logic/scope_cfg_top.sv */
`timescale 1ns/1ps

// scope configuration register block for two acquisition channels
module scope_cfg_top #(
  parameter int DW  = 14,
  parameter int RSZ = 14
) (
  input  logic                                                    adc_clk_i,
  input  logic                                                    adc_rstn_i,
  input  logic [scope_cfg_pkg::BUS_W-1:0]                         sys_addr_i,
  input  logic [scope_cfg_pkg::BUS_W-1:0]                         sys_wdata_i,
  input  logic                                                    sys_wen_i,
  input  logic                                                    sys_ren_i,
  output logic [scope_cfg_pkg::BUS_W-1:0]                         sys_rdata_o,
  output logic                                                    sys_ack_o,
  input  logic [scope_cfg_pkg::N_CH*RSZ-1:0]                      adc_wp_cur_i,
  output logic [scope_cfg_pkg::N_CH-1:0]                          adc_arm_do_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                          adc_rst_do_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                          adc_trig_sw_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                          adc_we_keep_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                          trig_dis_clr_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                          indep_mode_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                          new_trg_src_o,
  output logic [scope_cfg_pkg::N_CH-1:0]                          set_dec1_o,
  output logic [scope_cfg_pkg::N_CH*scope_cfg_pkg::TRG_SRC_W-1:0] trg_src_o,
  output logic [scope_cfg_pkg::N_CH*DW-1:0]                       set_tresh_o,
  output logic [scope_cfg_pkg::N_CH*DW-1:0]                       set_hyst_o,
  output logic [scope_cfg_pkg::N_CH*scope_cfg_pkg::DLY_W-1:0]     set_dly_o,
  output logic [scope_cfg_pkg::N_CH*scope_cfg_pkg::DEC_W-1:0]     set_dec_o
);

  import scope_cfg_pkg::*;

  // per-channel values before channel 1 mirroring
  logic [N_CH-1:0]           arm_raw;
  logic [N_CH-1:0]           rst_raw;
  logic [N_CH-1:0]           trig_sw_raw;
  logic [N_CH-1:0]           we_keep_raw;
  logic [N_CH-1:0]           trig_clr_raw;
  logic [N_CH-1:0]           indep_raw;
  logic [N_CH-1:0]           new_src_raw;
  logic [N_CH*TRG_SRC_W-1:0] trg_src_raw;
  logic [N_CH*DLY_W-1:0]     set_dly_raw;
  logic [N_CH*DEC_W-1:0]     set_dec_raw;

  scope_cmd_decode u_cmd (
    .adc_clk_i(adc_clk_i), .adc_rstn_i(adc_rstn_i),
    .sys_addr_i(sys_addr_i), .sys_wdata_i(sys_wdata_i), .sys_wen_i(sys_wen_i),
    .arm_o(arm_raw), .rst_o(rst_raw), .trig_sw_o(trig_sw_raw), .we_keep_o(we_keep_raw),
    .trig_clr_o(trig_clr_raw), .indep_o(indep_raw), .new_src_o(new_src_raw),
    .trg_src_o(trg_src_raw)
  );

  scope_set_regs #(.DW(DW)) u_set (
    .adc_clk_i(adc_clk_i), .adc_rstn_i(adc_rstn_i),
    .sys_addr_i(sys_addr_i), .sys_wdata_i(sys_wdata_i), .sys_wen_i(sys_wen_i),
    .set_tresh_o(set_tresh_o), .set_hyst_o(set_hyst_o),
    .set_dly_o(set_dly_raw), .set_dec_o(set_dec_raw)
  );

  scope_chan_mux u_mux (
    .adc_clk_i(adc_clk_i),
    .arm_i(arm_raw), .rst_i(rst_raw), .trig_sw_i(trig_sw_raw), .we_keep_i(we_keep_raw),
    .trig_clr_i(trig_clr_raw), .indep_i(indep_raw), .new_src_i(new_src_raw),
    .trg_src_i(trg_src_raw), .set_dly_i(set_dly_raw), .set_dec_i(set_dec_raw),
    .adc_arm_do_o(adc_arm_do_o), .adc_rst_do_o(adc_rst_do_o),
    .adc_trig_sw_o(adc_trig_sw_o), .adc_we_keep_o(adc_we_keep_o),
    .trig_dis_clr_o(trig_dis_clr_o), .indep_mode_o(indep_mode_o),
    .new_trg_src_o(new_trg_src_o), .trg_src_o(trg_src_o),
    .set_dly_o(set_dly_o), .set_dec_o(set_dec_o), .set_dec1_o(set_dec1_o)
  );

  // readback shows each channel's own stored settings
  scope_read_mux #(.DW(DW), .RSZ(RSZ)) u_rd (
    .adc_clk_i(adc_clk_i), .adc_rstn_i(adc_rstn_i),
    .sys_addr_i(sys_addr_i), .sys_wen_i(sys_wen_i), .sys_ren_i(sys_ren_i),
    .set_tresh_i(set_tresh_o), .set_hyst_i(set_hyst_o),
    .set_dly_i(set_dly_raw), .set_dec_i(set_dec_raw), .adc_wp_cur_i(adc_wp_cur_i),
    .sys_rdata_o(sys_rdata_o), .sys_ack_o(sys_ack_o)
  );

endmodule

/* bench/scope_cfg_tests.svh */
`ifndef SCOPE_CFG_TESTS_SVH
`define SCOPE_CFG_TESTS_SVH

// channel 1 follows channel 0 while it is not independent
function automatic logic [N_CH-1:0] mirror(input logic [N_CH-1:0] raw);
  return exp_indep[1] ? raw : {raw[0], raw[0]};
endfunction

// zero-extended value that a settings address reads back
function automatic logic [BUS_W-1:0] stored_setting(input logic [BUS_W-1:0] addr);
  case (addr[ADDR_W-1:0])
    REG_THRESH_A: return BUS_W'(exp_thr[0]);
    REG_THRESH_B: return BUS_W'(exp_thr[1]);
    REG_HYST_A:   return BUS_W'(exp_hyst[0]);
    REG_HYST_B:   return BUS_W'(exp_hyst[1]);
    REG_DLY_A:    return BUS_W'(exp_dly[0]);
    REG_DLY_B:    return BUS_W'(exp_dly[1]);
    REG_DEC_A:    return BUS_W'(exp_dec[0]);
    REG_DEC_B:    return BUS_W'(exp_dec[1]);
    default:      return '0;
  endcase
endfunction

task automatic check_outputs();
  int c1;
  c1 = exp_indep[1] ? 1 : 0;
  check_value("set_tresh_o", set_tresh, {exp_thr[1], exp_thr[0]});
  check_value("set_hyst_o", set_hyst, {exp_hyst[1], exp_hyst[0]});
  check_value("set_dly_o", set_dly, {exp_dly[c1], exp_dly[0]});
  check_value("set_dec_o", set_dec, {exp_dec[c1], exp_dec[0]});
  check_value("set_dec1_o", set_dec1, {exp_dec[c1] == 17'd1, exp_dec[0] == 17'd1});
  check_value("trg_src_o", trg_src, {exp_src[c1], exp_src[0]});
  check_value("indep_mode_o", indep_mode, exp_indep);
  check_value("adc_we_keep_o", we_keep, mirror(exp_keep));
endtask

task automatic check_strobes(input logic [N_CH-1:0] arm, rst, sw, clr, nsrc);
  check_value("adc_arm_do_o", arm_do, mirror(arm));
  check_value("adc_rst_do_o", rst_do, mirror(rst));
  check_value("adc_trig_sw_o", trig_sw, mirror(sw));
  check_value("trig_dis_clr_o", dis_clr, mirror(clr));
  check_value("new_trg_src_o", new_src, mirror(nsrc));
endtask

task automatic write_setting(input logic [BUS_W-1:0] addr, input logic [BUS_W-1:0] data);
  write_reg(addr, data);
  case (addr[ADDR_W-1:0])
    REG_THRESH_A: exp_thr[0] = data[DW-1:0];
    REG_THRESH_B: exp_thr[1] = data[DW-1:0];
    REG_HYST_A:   exp_hyst[0] = data[DW-1:0];
    REG_HYST_B:   exp_hyst[1] = data[DW-1:0];
    REG_DLY_A:    exp_dly[0] = data[DLY_W-1:0];
    REG_DLY_B:    exp_dly[1] = data[DLY_W-1:0];
    REG_DEC_A:    exp_dec[0] = data[DEC_W-1:0];
    REG_DEC_B:    exp_dec[1] = data[DEC_W-1:0];
    default:      ;
  endcase
  check_outputs();
  read_expect(addr, stored_setting(addr));
endtask

// strobes must show one cycle after the write and be gone a cycle later
task automatic ctrl_write(input logic [BUS_W-1:0] data);
  logic [7:0]      lane;
  logic [N_CH-1:0] arm;
  logic [N_CH-1:0] rst;
  for (int ch = 0; ch < N_CH; ch++) begin
    lane    = data[ch*8 +: 8];
    arm[ch] = lane[CTRL_ARM_BIT];
    rst[ch] = lane[CTRL_RST_BIT];
    if (lane != 8'h00) begin
      exp_keep[ch]  = lane[CTRL_KEEP_BIT];
      exp_indep[ch] = lane[CTRL_INDEP_BIT];
    end
  end
  write_reg(REG_CTRL, data);
  check_strobes(arm, rst, '0, '0, '0);
  check_outputs();
  idle_cycle();
  check_strobes('0, '0, '0, '0, '0);
endtask

task automatic trig_write(input logic [BUS_W-1:0] data);
  logic [TRG_SRC_W-1:0] src;
  logic [N_CH-1:0]      sw;
  logic [N_CH-1:0]      nsrc;
  for (int ch = 0; ch < N_CH; ch++) begin
    src      = data[ch*8 +: TRG_SRC_W];
    sw[ch]   = (src == 4'd1);
    nsrc[ch] = (src != 4'd0);
    if (src != 4'd0) begin
      exp_src[ch] = src;
    end
  end
  write_reg(REG_TRIG, data);
  check_strobes('0, '0, sw, '0, nsrc);
  check_outputs();
  idle_cycle();
  check_strobes('0, '0, '0, '0, '0);
endtask

task automatic clr_write(input logic [BUS_W-1:0] data);
  write_reg(REG_TRIG_CLR, data);
  check_strobes('0, '0, '0, {data[8], data[0]}, '0);
  idle_cycle();
  check_strobes('0, '0, '0, '0, '0);
endtask

task automatic test_reset();
  check_strobes('0, '0, '0, '0, '0);
  check_value("indep_mode_o", indep_mode, 2'b00);
  check_value("adc_we_keep_o", we_keep, 2'b00);
  check_value("set_dec1_o", set_dec1, 2'b11);
  check_value("sys_ack_o", sys_ack, 1'b0);
  check_outputs();
  read_expect(REG_THRESH_A, 32'h0000_1388);
  read_expect(REG_THRESH_B, 32'h0000_2c78);
  read_expect(REG_HYST_A, 32'd20);
  read_expect(REG_HYST_B, 32'd20);
  read_expect(REG_DLY_A, 32'd0);
  read_expect(REG_DLY_B, 32'd0);
  read_expect(REG_DEC_A, 32'd1);
  read_expect(REG_DEC_B, 32'd1);
endtask

task automatic test_settings();
  ctrl_write(32'h0000_2000);
  for (int i = 0; i < 8; i++) begin
    write_setting(SET_ADDRS[i], next_rand());
  end
  // bit 17 lies above the decimation field
  write_setting(REG_DEC_A, 32'h0002_0001);
  write_setting(REG_DEC_B, 32'h0000_0001);
  write_setting(REG_DEC_A, 32'h0000_0003);
  write_setting(REG_DEC_A, 32'h0000_0001);
  check_value("set_dec1_o", set_dec1, 2'b11);
endtask

task automatic test_ctrl_indep();
  ctrl_write(32'h0000_0001);
  ctrl_write(32'h0000_0002);
  ctrl_write(32'h0000_2100);
  ctrl_write(32'h0000_2200);
  ctrl_write(32'h0000_2303);
  ctrl_write(32'h0000_2808);
  // zero lanes leave keep alone and a nonzero lane 0 reloads it
  ctrl_write(32'h0000_0000);
  ctrl_write(32'h0000_0001);
  check_value("adc_we_keep_o", we_keep, 2'b10);
endtask

task automatic test_mirror();
  ctrl_write(32'h0000_0400);
  write_setting(REG_DLY_B, next_rand());
  write_setting(REG_DEC_B, next_rand());
  write_setting(REG_DLY_A, next_rand());
  trig_write(32'h0000_0300);
  trig_write(32'h0000_0006);
  ctrl_write(32'h0000_0209);
  clr_write(32'h0000_0100);
  trig_write(32'h0000_0001);
  // channel 1 shows its own source 3 again once independent
  ctrl_write(32'h0000_2000);
  check_value("trg_src_o", trg_src, {4'd3, 4'd1});
endtask

task automatic test_trigger();
  trig_write(32'h0000_0100);
  trig_write(32'h0000_0005);
  trig_write(32'h0000_0a00);
  trig_write(32'h0000_0000);
  trig_write(32'h0000_f0f0);
  clr_write(32'h0000_0001);
  clr_write(32'h0000_0100);
  clr_write(32'h0000_0202);
  check_value("trg_src_o", trg_src, {4'ha, 4'h5});
endtask

task automatic test_readback();
  logic [BUS_W-1:0]    rnd;
  logic [N_CH*RSZ-1:0] wp;
  rnd = next_rand();
  wp  = rnd[N_CH*RSZ-1:0];
  adc_wp_cur = wp;
  read_expect(REG_WP_A, BUS_W'(wp[RSZ-1:0]));
  read_expect(REG_WP_B, BUS_W'(wp[2*RSZ-1:RSZ]));
  // every pointer bit flipped
  wp = ~wp;
  adc_wp_cur = wp;
  read_expect(REG_WP_A, BUS_W'(wp[RSZ-1:0]));
  read_expect(REG_WP_B, BUS_W'(wp[2*RSZ-1:RSZ]));
  // back-to-back reads of control, trigger and unmapped offsets
  read_expect(REG_CTRL, '0);
  read_expect(REG_TRIG, '0);
  read_expect(32'h0000_001c, '0);
  read_expect(32'h0000_0028, '0);
  read_expect(32'h0000_0090, '0);
  read_expect(32'h0000_0098, '0);
  read_expect(32'h0000_011c, '0);
  read_expect(32'h000f_fffc, '0);
  idle_cycle();
  write_reg(32'h0000_0200, next_rand());
  idle_cycle();
  check_outputs();
endtask

`endif

/* bench/scope_cfg_tb.sv */
`timescale 1ns/1ps

module scope_cfg_tb;

  import scope_cfg_pkg::*;

  localparam int DW         = 14;
  localparam int RSZ        = 14;
  localparam int RST_CYCLES = 4;
  // about 80 bus operations, each at most two cycles, doubled for margin
  localparam int BUS_OPS        = 80;
  localparam int TIMEOUT_CYCLES = RST_CYCLES + 2 * 2 * BUS_OPS;

  localparam logic [BUS_W-1:0] SET_ADDRS [8] = '{
    REG_THRESH_A, REG_THRESH_B, REG_HYST_A, REG_HYST_B,
    REG_DLY_A, REG_DEC_A, REG_DLY_B, REG_DEC_B
  };

  logic                     adc_clk = 1'b0;
  logic                     adc_rstn;
  logic [BUS_W-1:0]         sys_addr;
  logic [BUS_W-1:0]         sys_wdata;
  logic                     sys_wen;
  logic                     sys_ren;
  logic [BUS_W-1:0]         sys_rdata;
  logic                     sys_ack;
  logic [N_CH*RSZ-1:0]      adc_wp_cur;
  logic [N_CH-1:0]          arm_do;
  logic [N_CH-1:0]          rst_do;
  logic [N_CH-1:0]          trig_sw;
  logic [N_CH-1:0]          we_keep;
  logic [N_CH-1:0]          dis_clr;
  logic [N_CH-1:0]          indep_mode;
  logic [N_CH-1:0]          new_src;
  logic [N_CH-1:0]          set_dec1;
  logic [N_CH*TRG_SRC_W-1:0] trg_src;
  logic [N_CH*DW-1:0]       set_tresh;
  logic [N_CH*DW-1:0]       set_hyst;
  logic [N_CH*DLY_W-1:0]    set_dly;
  logic [N_CH*DEC_W-1:0]    set_dec;

  // reference model of the stored registers and sticky bits
  logic [DW-1:0]        exp_thr  [N_CH];
  logic [DW-1:0]        exp_hyst [N_CH];
  logic [DLY_W-1:0]     exp_dly  [N_CH];
  logic [DEC_W-1:0]     exp_dec  [N_CH];
  logic [TRG_SRC_W-1:0] exp_src  [N_CH];
  logic [N_CH-1:0]      exp_keep;
  logic [N_CH-1:0]      exp_indep;

  logic [31:0] lcg_state = 32'hdd51_088b;
  int          errors    = 0;
  int          checks    = 0;
  int          cycle_cnt = 0;

  scope_cfg_top #(.DW(DW), .RSZ(RSZ)) i_dut (
    .adc_clk_i(adc_clk), .adc_rstn_i(adc_rstn),
    .sys_addr_i(sys_addr), .sys_wdata_i(sys_wdata), .sys_wen_i(sys_wen),
    .sys_ren_i(sys_ren), .sys_rdata_o(sys_rdata), .sys_ack_o(sys_ack),
    .adc_wp_cur_i(adc_wp_cur),
    .adc_arm_do_o(arm_do), .adc_rst_do_o(rst_do), .adc_trig_sw_o(trig_sw),
    .adc_we_keep_o(we_keep), .trig_dis_clr_o(dis_clr), .indep_mode_o(indep_mode),
    .new_trg_src_o(new_src), .set_dec1_o(set_dec1), .trg_src_o(trg_src),
    .set_tresh_o(set_tresh), .set_hyst_o(set_hyst),
    .set_dly_o(set_dly), .set_dec_o(set_dec)
  );

  initial begin
    forever #20 adc_clk = ~adc_clk;
  end

  always @(posedge adc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // all bus tasks start and end on a falling edge
  task automatic write_reg(input logic [BUS_W-1:0] addr, input logic [BUS_W-1:0] data);
    sys_addr  = addr;
    sys_wdata = data;
    sys_wen   = 1'b1;
    @(negedge adc_clk);
    sys_wen = 1'b0;
    check_value("sys_ack_o", sys_ack, 1'b1);
  endtask

  task automatic read_reg(input logic [BUS_W-1:0] addr, output logic [BUS_W-1:0] data);
    sys_addr = addr;
    sys_ren  = 1'b1;
    @(negedge adc_clk);
    sys_ren = 1'b0;
    check_value("sys_ack_o", sys_ack, 1'b1);
    data = sys_rdata;
  endtask

  task automatic read_expect(input logic [BUS_W-1:0] addr, input logic [BUS_W-1:0] exp);
    logic [BUS_W-1:0] data;
    read_reg(addr, data);
    check_value($sformatf("sys_rdata_o @0x%0h", addr), data, exp);
  endtask

  task automatic idle_cycle();
    @(negedge adc_clk);
    check_value("sys_ack_o", sys_ack, 1'b0);
  endtask

  `include "scope_cfg_tests.svh"

  initial begin
    adc_rstn   = 1'b0;
    sys_addr   = '0;
    sys_wdata  = '0;
    sys_wen    = 1'b0;
    sys_ren    = 1'b0;
    adc_wp_cur = '0;
    exp_thr[0] = DW'(5000);
    exp_thr[1] = DW'(-5000);
    for (int ch = 0; ch < N_CH; ch++) begin
      exp_hyst[ch] = DW'(20);
      exp_dly[ch]  = '0;
      exp_dec[ch]  = DEC_W'(1);
      exp_src[ch]  = '0;
    end
    exp_keep  = '0;
    exp_indep = '0;
    repeat (RST_CYCLES) @(negedge adc_clk);
    adc_rstn = 1'b1;
    test_reset();
    test_settings();
    test_ctrl_indep();
    test_mirror();
    test_trigger();
    test_readback();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+bench
logic/scope_cfg_pkg.sv
logic/scope_cmd_decode.sv
logic/scope_set_regs.sv
logic/scope_chan_mux.sv
logic/scope_read_mux.sv
logic/scope_cfg_top.sv
bench/scope_cfg_tb.sv

/* Makefile */
SIM      := verilator
TOP      := scope_cfg_tb
FLIST    := flist.f
OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
PASS_MSG := Test completed successfully
SOURCES  := $(shell grep -v '^+' $(FLIST)) $(wildcard bench/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
